// File: flist.f
source/ethpipe_pkg.sv
source/slot_wr_if.sv
source/rx_frame_writer.sv
source/rx_slot_ram.sv
source/rx_slot_ctrl.sv
source/ethpipe_rx_top.sv
dv/tb_clk_gen.sv
dv/tb_ethpipe.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_ethpipe -f flist.f -o tb_ethpipe \
  && ./obj_dir/tb_ethpipe > sim.log 2>&1 \
  || echo "build or simulation exited with an error" >> sim.log

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0

// File: dv/tb_ethpipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ethpipe;
  import ethpipe_pkg::*;

  localparam int SLOT_ADDR_W     = 5;
  localparam int CAP_BYTES       = 2 ** (SLOT_ADDR_W + 1);
  localparam int N_FRAMES        = 14;
  localparam int WATCHDOG_CYCLES = N_FRAMES * 200 + 1000;

  logic                   gmii_rx_clk;
  logic                   sys_rst;
  byte_t                  gmii_rxd;
  logic                   gmii_rx_dv;
  timestamp_t             global_counter;
  logic [SLOT_ADDR_W-1:0] host_rd_addr;
  logic                   slot_release;
  slot_word_t             host_rd_data;
  logic                   slot_full;
  frame_len_t             rx_frame_len;
  timestamp_t             rx_timestamp;
  logic                   rx_complete;

  // Reference model of the held frame
  byte_t      exp_mem [CAP_BYTES];
  frame_len_t exp_len;
  timestamp_t exp_ts;
  logic       first_byte;
  logic       cap_last;
  logic       rd_check;
  slot_word_t rd_exp;
  slot_word_t rd_mask;

  // Delayed copies lined up with DUT output timing
  logic       rst_q;
  logic       last_q1;
  logic       last_q2;
  logic       cmp_q;
  logic       rel_q;
  logic       rd_q;
  slot_word_t exp_q;
  slot_word_t mask_q;

  int mismatch_cnt = 0;
  int timeout_cnt  = 0;

  tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(2)) clk_gen0 (.clk(gmii_rx_clk), .rst(sys_rst));

  ethpipe_rx_top #(.SLOT_ADDR_W(SLOT_ADDR_W)) dut0 (
    .gmii_rx_clk    (gmii_rx_clk),
    .sys_rst        (sys_rst),
    .gmii_rxd       (gmii_rxd),
    .gmii_rx_dv     (gmii_rx_dv),
    .global_counter (global_counter),
    .host_rd_addr   (host_rd_addr),
    .host_rd_data   (host_rd_data),
    .slot_release   (slot_release),
    .slot_full      (slot_full),
    .rx_frame_len   (rx_frame_len),
    .rx_timestamp   (rx_timestamp),
    .rx_complete    (rx_complete)
  );

  // Free-running timestamp source
  initial begin
    global_counter = '0;
    forever begin
      @(posedge gmii_rx_clk);
      #1;
      global_counter = global_counter + 32'd1;
    end
  end

  always @(posedge gmii_rx_clk) begin
    rst_q  <= sys_rst;
    exp_q  <= rd_exp;
    mask_q <= rd_mask;
    if (sys_rst) begin
      last_q1 <= 1'b0;
      last_q2 <= 1'b0;
      cmp_q   <= 1'b0;
      rel_q   <= 1'b0;
      rd_q    <= 1'b0;
      exp_ts  <= '0;
    end else begin
      last_q1 <= cap_last;
      last_q2 <= last_q1;
      cmp_q   <= last_q2;
      // Stimulus only strobes release while a frame is held
      rel_q   <= slot_release;
      rd_q    <= rd_check;
      if (first_byte) begin
        exp_ts <= global_counter;
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    mismatch_cnt++;
    $display("MISMATCH %s expected %0h got %0h at %0t", name, exp, got, $time);
  endtask

  a_reset_state : assert property (@(posedge gmii_rx_clk)
    (rst_q && !sys_rst) |-> ({slot_full, rx_complete, rx_frame_len, rx_timestamp} == '0)
  ) else report_mismatch("{slot_full,rx_complete,rx_frame_len,rx_timestamp}", 64'h0,
    64'($sampled({slot_full, rx_complete, rx_frame_len, rx_timestamp})));

  // Completion lands two cycles after the last byte, and never for a dropped frame
  a_complete_timing : assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    rx_complete == last_q2
  ) else report_mismatch("rx_complete", 64'($sampled(last_q2)), 64'($sampled(rx_complete)));

  a_full_set : assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    cmp_q |-> slot_full
  ) else report_mismatch("slot_full", 64'h1, 64'($sampled(slot_full)));

  a_full_clear : assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    rel_q |-> !slot_full
  ) else report_mismatch("slot_full", 64'h0, 64'($sampled(slot_full)));

  a_held_len : assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    slot_full |-> (rx_frame_len == exp_len)
  ) else report_mismatch("rx_frame_len", 64'($sampled(exp_len)), 64'($sampled(rx_frame_len)));

  a_held_ts : assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    slot_full |-> (rx_timestamp == exp_ts)
  ) else report_mismatch("rx_timestamp", 64'($sampled(exp_ts)), 64'($sampled(rx_timestamp)));

  a_read_data : assert property (@(posedge gmii_rx_clk) disable iff (sys_rst)
    rd_q |-> ((host_rd_data & mask_q) == exp_q)
  ) else report_mismatch("host_rd_data", 64'($sampled(exp_q)),
    64'($sampled(host_rd_data & mask_q)));

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  // rel_at picks a byte index that also strobes slot_release, -1 for none
  task automatic send_frame(input int len, input bit capture, input int rel_at);
    byte_t b;
    repeat (4) begin
      @(posedge gmii_rx_clk);
      #1;
      gmii_rx_dv = 1'b0;
    end
    if (capture) begin
      exp_len = frame_len_t'((len < CAP_BYTES) ? len : CAP_BYTES);
    end
    for (int k = 0; k < len; k++) begin
      @(posedge gmii_rx_clk);
      #1;
      b = byte_t'($urandom);
      gmii_rxd     = b;
      gmii_rx_dv   = 1'b1;
      first_byte   = capture && (k == 0);
      cap_last     = capture && (k == len - 1);
      slot_release = (k == rel_at);
      if (capture && k < CAP_BYTES) begin
        exp_mem[k] = b;
      end
    end
    @(posedge gmii_rx_clk);
    #1;
    gmii_rx_dv   = 1'b0;
    first_byte   = 1'b0;
    cap_last     = 1'b0;
    slot_release = 1'b0;
  endtask

  task automatic wait_full();
    @(negedge gmii_rx_clk);
    while (!slot_full) @(negedge gmii_rx_clk);
  endtask

  // Lanes past the frame end are masked out of the compare
  task automatic read_slot(input int nbytes);
    for (int w = 0; w < (nbytes + 1) / 2; w++) begin
      @(posedge gmii_rx_clk);
      #1;
      host_rd_addr = SLOT_ADDR_W'(w);
      rd_check     = 1'b1;
      rd_mask      = (2 * w + 1 < nbytes) ? 16'hffff : 16'h00ff;
      rd_exp       = {exp_mem[2 * w + 1], exp_mem[2 * w]} & rd_mask;
    end
    @(posedge gmii_rx_clk);
    #1;
    rd_check = 1'b0;
  endtask

  task automatic release_slot();
    @(posedge gmii_rx_clk);
    #1;
    slot_release = 1'b1;
    @(posedge gmii_rx_clk);
    #1;
    slot_release = 1'b0;
  endtask

  task automatic print_summary();
    $display("Errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge gmii_rx_clk);
    timeout_cnt++;
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    print_summary();
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(32'hc2e6));
    gmii_rxd     = '0;
    gmii_rx_dv   = 1'b0;
    host_rd_addr = '0;
    slot_release = 1'b0;
    first_byte   = 1'b0;
    cap_last     = 1'b0;
    rd_check     = 1'b0;
    rd_exp       = '0;
    rd_mask      = '0;
    exp_len      = '0;
    wait (!sys_rst);

    // Random frames, each read back and released
    repeat (8) begin
      send_frame(int'($urandom_range(60, 1)), 1'b1, -1);
      wait_full();
      read_slot(int'(exp_len));
      release_slot();
    end

    // Frame arriving on a full slot is dropped whole
    send_frame(int'($urandom_range(60, 1)), 1'b1, -1);
    wait_full();
    send_frame(30, 1'b0, -1);
    repeat (6) @(posedge gmii_rx_clk);
    read_slot(int'(exp_len));
    release_slot();

    // Release mid-frame, tail of that frame must not land
    send_frame(20, 1'b1, -1);
    wait_full();
    read_slot(int'(exp_len));
    send_frame(40, 1'b0, 10);
    send_frame(int'($urandom_range(60, 1)), 1'b1, -1);
    wait_full();
    read_slot(int'(exp_len));
    release_slot();

    // Oversized frame truncated to slot capacity
    send_frame(100, 1'b1, -1);
    wait_full();
    read_slot(int'(exp_len));
    release_slot();

    repeat (4) @(posedge gmii_rx_clk);
    print_summary();
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Synchronous reset held over the first rising edges
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: source/ethpipe_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module ethpipe_rx_top #(
  parameter int SLOT_ADDR_W = 10
) (
  input  wire                          gmii_rx_clk,
  input  wire                          sys_rst,

  // GMII receive
  input  wire ethpipe_pkg::byte_t      gmii_rxd,
  input  wire                          gmii_rx_dv,

  // Free-running timestamp source
  input  wire ethpipe_pkg::timestamp_t global_counter,

  // Host side
  input  wire [SLOT_ADDR_W-1:0]        host_rd_addr,
  output ethpipe_pkg::slot_word_t      host_rd_data,
  input  wire                          slot_release,
  output logic                         slot_full,
  output ethpipe_pkg::frame_len_t      rx_frame_len,
  output ethpipe_pkg::timestamp_t      rx_timestamp,
  output logic                         rx_complete
);
  import ethpipe_pkg::*;

  logic       slot_empty;
  logic       frame_done;
  frame_len_t frame_len;
  timestamp_t frame_ts;

  slot_wr_if #(.SLOT_ADDR_W(SLOT_ADDR_W)) slot_wr ();

  // ------------------------------------------------------------
  // Receive path
  // ------------------------------------------------------------
  rx_frame_writer #(
    .SLOT_ADDR_W (SLOT_ADDR_W)
  ) u_writer (
    .gmii_rx_clk    (gmii_rx_clk),
    .sys_rst        (sys_rst),
    .gmii_rxd       (gmii_rxd),
    .gmii_rx_dv     (gmii_rx_dv),
    .global_counter (global_counter),
    .slot_empty     (slot_empty),
    .wr             (slot_wr.writer),
    .frame_done     (frame_done),
    .frame_len      (frame_len),
    .frame_ts       (frame_ts)
  );

  rx_slot_ram #(
    .SLOT_ADDR_W (SLOT_ADDR_W)
  ) u_ram (
    .gmii_rx_clk (gmii_rx_clk),
    .wr          (slot_wr.ram),
    .rd_addr     (host_rd_addr),
    .rd_data     (host_rd_data)
  );

  // ------------------------------------------------------------
  // Slot handover to the host
  // ------------------------------------------------------------
  rx_slot_ctrl u_ctrl (
    .gmii_rx_clk  (gmii_rx_clk),
    .sys_rst      (sys_rst),
    .frame_done   (frame_done),
    .frame_len    (frame_len),
    .frame_ts     (frame_ts),
    .slot_release (slot_release),
    .slot_empty   (slot_empty),
    .slot_full    (slot_full),
    .held_len     (rx_frame_len),
    .held_ts      (rx_timestamp)
  );

  // Host sees completion in the same cycle as the writer
  assign rx_complete = frame_done;

endmodule

`default_nettype wire

// File: source/rx_slot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rx_slot_ctrl (
  input  wire                          gmii_rx_clk,
  input  wire                          sys_rst,
  input  wire                          frame_done,
  input  wire ethpipe_pkg::frame_len_t frame_len,
  input  wire ethpipe_pkg::timestamp_t frame_ts,
  input  wire                          slot_release,
  output logic                         slot_empty,
  output logic                         slot_full,
  output ethpipe_pkg::frame_len_t      held_len,
  output ethpipe_pkg::timestamp_t      held_ts
);

  // ------------------------------------------------------------
  // Slot ownership
  // ------------------------------------------------------------

  // Writer fills, host releases
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      slot_full <= 1'b0;
      held_len  <= '0;
      held_ts   <= '0;
    end else begin
      if (frame_done && !slot_full) begin
        slot_full <= 1'b1;
        held_len  <= frame_len;
        held_ts   <= frame_ts;
      end else if (slot_release && slot_full) begin
        // Length and timestamp stay until the next frame lands
        slot_full <= 1'b0;
      end
    end
  end

  // Level seen by the writer when deciding to arm
  assign slot_empty = !slot_full;

  // Writer must be disarmed for as long as the host owns the slot
  a_no_fill_when_full : assert property (
    @(posedge gmii_rx_clk) disable iff (sys_rst)
    frame_done |-> !slot_full
  );

endmodule

`default_nettype wire

// File: source/rx_slot_ram.sv
`timescale 1ns/1ps
`default_nettype none

module rx_slot_ram #(
  parameter int SLOT_ADDR_W = 10
) (
  input  wire                     gmii_rx_clk,
  slot_wr_if.ram                  wr,
  input  wire [SLOT_ADDR_W-1:0]   rd_addr,
  output ethpipe_pkg::slot_word_t rd_data
);
  import ethpipe_pkg::*;

  localparam int DEPTH = 2 ** SLOT_ADDR_W;

  slot_word_t mem [DEPTH];

  // ------------------------------------------------------------
  // Write port with per-lane enables
  // ------------------------------------------------------------
  always_ff @(posedge gmii_rx_clk) begin
    if (wr.wr_en) begin
      if (wr.lane_en[0]) begin
        mem[wr.address][7:0] <= wr.data[7:0];
      end
      if (wr.lane_en[1]) begin
        mem[wr.address][15:8] <= wr.data[15:8];
      end
    end
  end

  // ------------------------------------------------------------
  // Host read port
  // ------------------------------------------------------------

  // Registered read, data follows the address by one cycle
  always_ff @(posedge gmii_rx_clk) begin
    rd_data <= mem[rd_addr];
  end

  // A write beat with no lane selected would be lost silently
  a_lane_nonzero : assert property (
    @(posedge gmii_rx_clk)
    wr.wr_en |-> (wr.lane_en != '0)
  );

endmodule

`default_nettype wire

// File: source/rx_frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer #(
  parameter int SLOT_ADDR_W = 10
) (
  input  wire                     gmii_rx_clk,
  input  wire                     sys_rst,
  input  wire ethpipe_pkg::byte_t gmii_rxd,
  input  wire                     gmii_rx_dv,
  input  wire ethpipe_pkg::timestamp_t global_counter,
  input  wire                     slot_empty,
  slot_wr_if.writer               wr,
  output logic                    frame_done,
  output ethpipe_pkg::frame_len_t frame_len,
  output ethpipe_pkg::timestamp_t frame_ts
);
  import ethpipe_pkg::*;

  // Slot capacity in bytes, two per word
  localparam frame_len_t CAP_BYTES = frame_len_t'(2 ** (SLOT_ADDR_W + 1));

  // ------------------------------------------------------------
  // Receive FSM encoding
  // ------------------------------------------------------------
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ARMED = 2'd1;
  localparam logic [1:0] ST_RECV  = 2'd2;
  localparam logic [1:0] ST_DONE  = 2'd3;

  logic [1:0] state;
  frame_len_t byte_cnt;
  logic       armed;
  logic       room;
  logic       accept;

  // Armed covers both waiting for the first byte and mid-frame
  assign armed  = (state == ST_ARMED) || (state == ST_RECV);
  assign room   = (byte_cnt < CAP_BYTES);
  // Bytes past capacity are dropped without counting
  assign accept = armed && gmii_rx_dv && room;

  // ------------------------------------------------------------
  // Control path
  // ------------------------------------------------------------
  always_ff @(posedge gmii_rx_clk) begin
    if (sys_rst) begin
      state    <= ST_IDLE;
      byte_cnt <= '0;
      frame_ts <= '0;
      wr.wr_en <= 1'b0;
    end else begin
      wr.wr_en <= accept;
      if (accept) begin
        byte_cnt <= byte_cnt + frame_len_t'(1);
      end

      case (state)
        ST_IDLE: begin
          // Only arm on a quiet line so capture never starts mid-frame
          if (slot_empty && !gmii_rx_dv) begin
            state    <= ST_ARMED;
            byte_cnt <= '0;
          end
        end
        ST_ARMED: begin
          if (gmii_rx_dv) begin
            state    <= ST_RECV;
            frame_ts <= global_counter;
          end
        end
        ST_RECV: begin
          // First idle cycle after data ends the frame
          if (!gmii_rx_dv) begin
            state <= ST_DONE;
          end
        end
        default: begin
          // One cycle of frame_done, then wait for the slot to empty again
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Write beat payload
  // ------------------------------------------------------------
  always_ff @(posedge gmii_rx_clk) begin
    if (accept) begin
      wr.address <= byte_cnt[SLOT_ADDR_W:1];
      wr.lane_en <= byte_cnt[0] ? LANE_HI : LANE_LO;
      // Byte on both lanes, lane_en picks the one that lands
      wr.data    <= {gmii_rxd, gmii_rxd};
    end
  end

  assign frame_done = (state == ST_DONE);
  // Counter holds its final value through the DONE cycle
  assign frame_len  = byte_cnt;

  // Each write beat touches exactly one byte lane
  a_lane_onehot : assert property (
    @(posedge gmii_rx_clk) disable iff (sys_rst)
    wr.wr_en |-> $onehot(wr.lane_en)
  );

  // A frame completes at most once per receive cycle
  a_done_single : assert property (
    @(posedge gmii_rx_clk) disable iff (sys_rst)
    frame_done |=> !frame_done
  );

endmodule

`default_nettype wire

// File: source/slot_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Byte write beats into the slot memory, one lane per beat, no stall
interface slot_wr_if #(
  parameter int SLOT_ADDR_W = 10
);
  import ethpipe_pkg::*;

  logic                   wr_en;
  logic [SLOT_ADDR_W-1:0] address;
  lane_en_t               lane_en;
  slot_word_t             data;

  modport writer (
    output wr_en,
    output address,
    output lane_en,
    output data
  );

  modport ram (
    input wr_en,
    input address,
    input lane_en,
    input data
  );

endinterface

`default_nettype wire

// File: source/ethpipe_pkg.sv
`default_nettype none

package ethpipe_pkg;

  // ------------------------------------------------------------
  // GMII and slot memory data
  // ------------------------------------------------------------

  // One byte off the GMII receive bus
  typedef logic [7:0] byte_t;

  // Slot word, lane 0 low byte (even offsets), lane 1 high byte (odd offsets)
  typedef logic [15:0] slot_word_t;

  // One-hot lane select for a single byte write
  typedef logic [1:0] lane_en_t;

  localparam lane_en_t LANE_LO = 2'b01;
  localparam lane_en_t LANE_HI = 2'b10;

  // ------------------------------------------------------------
  // Frame descriptor
  // ------------------------------------------------------------

  // Byte count of one captured frame
  typedef logic [11:0] frame_len_t;

  // Copy of the free-running global counter
  typedef logic [31:0] timestamp_t;

endpackage

`default_nettype wire
